/* filelist.f */
+incdir+logic
logic/sd_host_pkg.sv
logic/crc7_serial.sv
logic/cmd_phys.sv
logic/cmd_controller.sv
logic/registers.sv
logic/wishbone_slave.sv
logic/sd_host.sv
testbench/sd_card_model.sv
testbench/tb_sd_host.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SD host regression with Verilator, result in sim.log
rm -f sim.log
{ verilator --binary --timing --assert -f filelist.f --top-module tb_sd_host \
	&& ./obj_dir/Vtb_sd_host || echo "Build or simulation did not complete"; } 2>&1 | tee sim.log
grep -q "^Regression passed$" sim.log && echo "PASS" && exit 0 || { echo "FAIL, see sim.log"; exit 1; }

/* testbench/tb_sd_host.sv */
// Regression for the SD host command path against a behavioral card.
// Bus inputs change 2 ns after the rising clock edge, replies are read there.
// At most 12 commands fit in the cycle limit.
`timescale 1ns/1ns
`include "sd_host_macros.svh"

module tb_sd_host;
	import sd_host_pkg::*;

	localparam logic [1:0] MODE_REPLY   = 2'd0;
	localparam logic [1:0] MODE_SILENT  = 2'd1;
	localparam logic [1:0] MODE_BAD_CRC = 2'd2;
	localparam logic [1:0] MODE_INDEX   = 2'd3;
	localparam int MAX_CYCLES = 12 * (48 + 48 + `SD_RESP_TIMEOUT) * `SD_CLK_DIV + 2000;

	logic        clock = 1'b0;
	logic        reset_i, strobe_i, we_i;
	logic [4:0]  adr_i;
	bus_word_t   wb_data_i, wb_data_o;
	logic        ack_o, error_o, sd_clk, cmd_host, cmd_oe, cmd_card;
	logic [1:0]  card_mode;
	logic [47:0] card_frame;
	int          card_frames, card_bad;
	int          errors, cmd_count;
	int          cycles = 0;
	integer      seed;

	sd_host dut0 (
		.clock(clock), .reset_i(reset_i), .strobe_i(strobe_i), .we_i(we_i), .adr_i(adr_i),
		.wb_data_i(wb_data_i), .wb_data_o(wb_data_o), .ack_o(ack_o), .error_o(error_o),
		.sd_clk_o(sd_clk), .cmd_o(cmd_host), .cmd_oe_o(cmd_oe), .cmd_i(cmd_card)
	);

	sd_card_model card0 (
		.sd_clk_i(sd_clk), .cmd_i(cmd_host), .cmd_oe_i(cmd_oe), .mode_i(card_mode),
		.cmd_o(cmd_card), .frame_o(card_frame), .frames_o(card_frames), .bad_frames_o(card_bad)
	);

	always #10 clock = ~clock; // 20 ns period

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Regression failed");
			$finish;
		end
	end

	// CRC7 over 40 bits, MSB first
	function automatic logic [6:0] crc7_ref(input logic [39:0] bits);
		logic [6:0] crc;
		logic       fb;
		crc = '0;
		for (int i = 39; i >= 0; i--) begin
			fb  = bits[i] ^ crc[6];
			crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
		end
		return crc;
	endfunction

	// Card reply frame for a given command and card mode
	function automatic logic [47:0] expected_response(input logic [5:0] index,
		input bus_word_t arg, input logic [1:0] mode);
		logic [5:0]  idx;
		logic [39:0] head;
		logic [6:0]  crc;
		idx  = (mode == MODE_INDEX) ? index + 6'd1 : index;
		head = {2'b00, idx, ~arg};
		crc  = crc7_ref(head);
		if (mode == MODE_BAD_CRC) crc = crc ^ 7'h01;
		return {head, crc, 1'b1};
	endfunction

	task automatic check(input string name, input logic [63:0] expected, input logic [63:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic bus_write(input logic [4:0] adr, input bus_word_t data,
		output logic ack, output logic err);
		@(posedge clock);
		#2;
		strobe_i  = 1'b1;
		we_i      = 1'b1;
		adr_i     = adr;
		wb_data_i = data;
		@(posedge clock);
		#2;
		strobe_i = 1'b0; // Single-cycle strobe
		we_i     = 1'b0;
		ack      = ack_o;
		err      = error_o;
	endtask

	task automatic bus_read(input logic [4:0] adr, output bus_word_t data,
		output logic ack, output logic err);
		@(posedge clock);
		#2;
		strobe_i = 1'b1;
		we_i     = 1'b0;
		adr_i    = adr;
		@(posedge clock);
		#2;
		strobe_i = 1'b0;
		data     = wb_data_o; // Valid in the reply cycle
		ack      = ack_o;
		err      = error_o;
	endtask

	task automatic write_reg(input logic [1:0] adr, input bus_word_t data, input string name);
		logic ack, err;
		bus_write({3'b000, adr}, data, ack, err);
		check({name, " ack"}, 64'(1'b1), 64'(ack));
		check({name, " error"}, 64'(1'b0), 64'(err));
	endtask

	task automatic read_reg(input logic [1:0] adr, output bus_word_t data, input string name);
		logic ack, err;
		bus_read({3'b000, adr}, data, ack, err);
		check({name, " ack"}, 64'(1'b1), 64'(ack));
		check({name, " error"}, 64'(1'b0), 64'(err));
	endtask

	task automatic wait_idle(output bus_word_t st);
		st = 32'h400;
		while (st[10]) read_reg(`SD_ADR_STATUS, st, "status poll"); // Until busy falls
	endtask

	task automatic run_command(input string name, input logic [1:0] mode,
		input logic resp_en, input logic poke_busy);
		bus_word_t   rnd, arg, st, resp;
		logic [5:0]  index;
		logic [47:0] reply, exp_frame;
		sd_status_t  exp_st;
		logic        ack, err;
		int          frames_before;
		rnd           = $random(seed);
		index         = rnd[5:0];
		arg           = $random(seed);
		card_mode     = mode;
		frames_before = card_frames;
		write_reg(`SD_ADR_ARGUMENT, arg, {name, " argument"});
		write_reg(`SD_ADR_COMMAND, {25'd0, resp_en, index}, {name, " command"});
		if (poke_busy) begin // Second COMMAND while the first runs
			bus_write({3'b000, `SD_ADR_COMMAND}, 32'h7f, ack, err);
			check({name, " busy write error"}, 64'(1'b1), 64'(err));
			check({name, " busy write ack"}, 64'(1'b0), 64'(ack));
		end
		wait_idle(st);
		read_reg(`SD_ADR_RESPONSE, resp, {name, " response"});
		exp_frame = {2'b01, index, arg, crc7_ref({2'b01, index, arg}), 1'b1};
		check({name, " frames seen"}, 64'(frames_before + 1), 64'(card_frames));
		check({name, " frame"}, 64'(exp_frame), 64'(card_frame));
		reply       = expected_response(index, arg, mode);
		exp_st      = '0;
		exp_st.done = 1'b1;
		if (resp_en && mode == MODE_SILENT) begin
			exp_st.timeout = 1'b1; // Nothing came back
		end else if (resp_en) begin
			exp_st.resp_index = reply[45:40];
			exp_st.crc_err    = (mode == MODE_BAD_CRC);
			exp_st.index_err  = (reply[45:40] != index);
			check({name, " response arg"}, 64'(reply[39:8]), 64'(resp));
		end
		check({name, " status"}, 64'({21'd0, exp_st}), 64'(st));
		cmd_count++;
	endtask

	initial begin
		bus_word_t rnd, data;
		logic      ack, err;
		seed      = 32'h809;
		errors    = 0;
		cmd_count = 0;
		reset_i   = 1'b1;
		strobe_i  = 1'b0;
		we_i      = 1'b0;
		adr_i     = '0;
		wb_data_i = '0;
		card_mode = MODE_REPLY;
		repeat (5) @(posedge clock);
		#2 reset_i = 1'b0;
		check("reset ack", 64'(1'b0), 64'(ack_o));
		check("reset error", 64'(1'b0), 64'(error_o));
		check("reset cmd_oe", 64'(1'b0), 64'(cmd_oe));
		check("reset cmd", 64'(1'b1), 64'(cmd_host));
		check("reset sd_clk", 64'(1'b0), 64'(sd_clk));
		read_reg(`SD_ADR_STATUS, data, "reset status");
		check("reset status", 64'(0), 64'(data));

		for (int n = 0; n < 4; n++) begin // Register access
			rnd = $random(seed);
			write_reg(`SD_ADR_ARGUMENT, rnd, "argument write");
			read_reg(`SD_ADR_ARGUMENT, data, "argument read");
			check("argument readback", 64'(rnd), 64'(data));
		end

		repeat (3) run_command("cmd with response", MODE_REPLY, 1'b1, 1'b0);
		run_command("cmd without response", MODE_SILENT, 1'b0, 1'b0);
		run_command("silent card", MODE_SILENT, 1'b1, 1'b0);
		run_command("bad response crc", MODE_BAD_CRC, 1'b1, 1'b0);
		run_command("index mismatch", MODE_INDEX, 1'b1, 1'b0);

		bus_read(5'd7, data, ack, err); // Bus errors
		check("address 7 error", 64'(1'b1), 64'(err));
		check("address 7 ack", 64'(1'b0), 64'(ack));
		bus_write({3'b000, `SD_ADR_STATUS}, 32'hffff_ffff, ack, err);
		check("status write error", 64'(1'b1), 64'(err));
		check("status write ack", 64'(1'b0), 64'(ack));
		run_command("command while busy", MODE_REPLY, 1'b1, 1'b1);

		if (card_bad != 0) begin
			$display("Card model received %0d frames with a wrong CRC7", card_bad);
			errors += card_bad;
		end
		$display("Commands run %0d, errors %0d", cmd_count, errors);
		if (errors == 0) $display("Regression passed");
		else $display("Regression failed");
		$finish;
	end

endmodule

/* testbench/sd_card_model.sv */
// Behavioral SD card for the CMD line only.
// Samples host bits on the falling edge of sd_clk_i, because the host
// changes cmd_o on the rising edge. Replies 2 SD periods after the end bit.
// Modes: 0 reply, 1 silent, 2 bad CRC7, 3 echoed index plus one.
`timescale 1ns/1ns

module sd_card_model (
	input  logic        sd_clk_i,
	input  logic        cmd_i,        // Host CMD output
	input  logic        cmd_oe_i,     // Host drives the line
	input  logic [1:0]  mode_i,
	output logic        cmd_o,        // Into host cmd_i
	output logic [47:0] frame_o,      // Last command frame received
	output int          frames_o,     // Frames received
	output int          bad_frames_o  // Frames with bad CRC7 or end bit
);
	localparam logic [1:0] MODE_SILENT  = 2'd1;
	localparam logic [1:0] MODE_BAD_CRC = 2'd2;
	localparam logic [1:0] MODE_INDEX   = 2'd3;

	logic [47:0] frame, reply;
	logic [5:0]  idx;
	logic [6:0]  crc;

	function automatic logic [6:0] crc7_bits(input logic [39:0] bits);
		logic [6:0] c;
		logic       fb;
		c = '0;
		for (int i = 39; i >= 0; i--) begin
			fb = bits[i] ^ c[6];
			c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00); // x^7 + x^3 + 1
		end
		return c;
	endfunction

	initial begin
		cmd_o        = 1'b1; // Pull-up level
		frame_o      = '0;
		frames_o     = 0;
		bad_frames_o = 0;
		forever begin
			@(negedge sd_clk_i);
			if (cmd_oe_i && !cmd_i) begin // Start bit
				frame = '0;
				for (int i = 46; i >= 0; i--) begin
					@(negedge sd_clk_i);
					frame[i] = cmd_i;
				end
				frame_o  = frame;
				frames_o = frames_o + 1;
				if (crc7_bits(frame[47:8]) != frame[7:1] || !frame[0]) begin
					$display("Card model: command frame %h has a wrong CRC7 or end bit", frame);
					bad_frames_o = bad_frames_o + 1;
				end
				if (mode_i != MODE_SILENT) begin
					idx = (mode_i == MODE_INDEX) ? frame[45:40] + 6'd1 : frame[45:40];
					reply[47:8] = {2'b00, idx, ~frame[39:8]}; // Card bit, inverted arg
					crc = crc7_bits(reply[47:8]);
					if (mode_i == MODE_BAD_CRC) crc = crc ^ 7'h01; // Corrupt LSB
					reply[7:0] = {crc, 1'b1};
					repeat (2) @(negedge sd_clk_i); // Idle gap before start bit
					for (int i = 47; i >= 0; i--) begin
						#2 cmd_o = reply[i];
						@(negedge sd_clk_i);
					end
					#2 cmd_o = 1'b1;
				end
			end
		end
	end

endmodule

/* logic/sd_host.sv */
// SD host command path with a Wishbone-style register slave.
// One system clock, the SD clock is a divided output.
// The CMD pin is split into cmd_o, cmd_oe_o and cmd_i.
`timescale 1ns/1ns

module sd_host (
	input  logic                  clock,
	input  logic                  reset_i,
	input  logic                  strobe_i,
	input  logic                  we_i,
	input  logic [4:0]            adr_i,
	input  sd_host_pkg::bus_word_t wb_data_i,
	output sd_host_pkg::bus_word_t wb_data_o,
	output logic                  ack_o,
	output logic                  error_o,
	output logic                  sd_clk_o,
	output logic                  cmd_o,
	output logic                  cmd_oe_o,
	input  logic                  cmd_i
);
	import sd_host_pkg::*;

	logic        reg_write_en, reg_read_en; // Slave to registers
	logic [1:0]  reg_adr;
	bus_word_t   reg_wdata, reg_rdata;
	logic        new_cmd, busy;
	cmd_req_t    cmd_req, phys_req;
	logic        phys_start, phys_done;
	cmd_result_t phys_result;
	logic        cmd_done;
	sd_status_t  status;
	bus_word_t   resp_arg;

	wishbone_slave wb_slave0 (
		.clock(clock), .reset_i(reset_i),
		.strobe_i(strobe_i), .we_i(we_i), .adr_i(adr_i),
		.wb_data_i(wb_data_i), .reg_data_i(reg_rdata), .busy_i(busy),
		.wb_data_o(wb_data_o), .ack_o(ack_o), .error_o(error_o),
		.reg_write_en_o(reg_write_en), .reg_read_en_o(reg_read_en),
		.reg_adr_o(reg_adr), .reg_data_o(reg_wdata)
	);

	registers regs0 (
		.clock(clock), .reset_i(reset_i),
		.reg_write_en_i(reg_write_en), .reg_read_en_i(reg_read_en),
		.reg_adr_i(reg_adr), .reg_data_i(reg_wdata),
		.cmd_done_i(cmd_done), .status_i(status), .resp_arg_i(resp_arg), .busy_i(busy),
		.reg_data_o(reg_rdata), .new_cmd_o(new_cmd), .cmd_req_o(cmd_req)
	);

	cmd_controller cmd_ctrl0 (
		.clock(clock), .reset_i(reset_i),
		.new_cmd_i(new_cmd), .cmd_req_i(cmd_req),
		.phys_done_i(phys_done), .phys_result_i(phys_result),
		.phys_start_o(phys_start), .phys_req_o(phys_req),
		.cmd_done_o(cmd_done), .status_o(status), .resp_arg_o(resp_arg), .busy_o(busy)
	);

	cmd_phys cmd_phys0 (
		.clock(clock), .reset_i(reset_i),
		.start_i(phys_start), .req_i(phys_req), .cmd_i(cmd_i),
		.sd_clk_o(sd_clk_o), .cmd_o(cmd_o), .cmd_oe_o(cmd_oe_o),
		.done_o(phys_done), .result_o(phys_result)
	);

endmodule

/* logic/wishbone_slave.sv */
// Register slave for the SD host bus.
// Every strobe gets exactly one ack or error in the following cycle.
// No back-pressure. The master waits for the reply before the next strobe.
`timescale 1ns/1ns
`include "sd_host_macros.svh"

module wishbone_slave (
	input  logic                   clock,
	input  logic                   reset_i,
	input  logic                   strobe_i,
	input  logic                   we_i,
	input  logic [4:0]             adr_i,
	input  sd_host_pkg::bus_word_t wb_data_i,
	input  sd_host_pkg::bus_word_t reg_data_i,
	input  logic                   busy_i,
	output sd_host_pkg::bus_word_t wb_data_o,
	output logic                   ack_o,
	output logic                   error_o,
	output logic                   reg_write_en_o,
	output logic                   reg_read_en_o,
	output logic [1:0]             reg_adr_o,
	output sd_host_pkg::bus_word_t reg_data_o
);
	import sd_host_pkg::*;

	logic adr_ok, read_only, cmd_blocked, legal;
	logic cmd_pend_q; // COMMAND accepted last cycle before busy rises

	assign adr_ok      = (adr_i[4:2] == 3'd0); // Only words 0 to 3 exist
	assign read_only   = (adr_i[1:0] == `SD_ADR_RESPONSE) || (adr_i[1:0] == `SD_ADR_STATUS);
	assign cmd_blocked = (adr_i[1:0] == `SD_ADR_COMMAND) && (busy_i || cmd_pend_q);
	assign legal       = adr_ok && !(we_i && (read_only || cmd_blocked));

	assign reg_write_en_o = strobe_i && we_i && legal;
	assign reg_read_en_o  = strobe_i && !we_i && legal;
	assign reg_adr_o      = adr_i[1:0];
	assign reg_data_o     = wb_data_i;

	always_ff @(posedge clock) begin
		if (reset_i) begin
			ack_o      <= 1'b0;
			error_o    <= 1'b0;
			cmd_pend_q <= 1'b0;
		end else begin
			ack_o      <= strobe_i && legal;
			error_o    <= strobe_i && !legal;
			cmd_pend_q <= reg_write_en_o && (reg_adr_o == `SD_ADR_COMMAND);
		end
		if (reg_read_en_o) wb_data_o <= reg_data_i; // Read data for the reply cycle
	end

	ap_excl: assert property (@(posedge clock) disable iff (reset_i)
		!(ack_o && error_o));

endmodule

/* logic/registers.sv */
// Register bank: ARGUMENT, COMMAND, RESPONSE and STATUS.
// A COMMAND write launches a request with the stored ARGUMENT and
// clears done and the error flags. STATUS reads show live busy.
`timescale 1ns/1ns
`include "sd_host_macros.svh"

module registers (
	input  logic                     clock,
	input  logic                     reset_i,
	input  logic                     reg_write_en_i,
	input  logic                     reg_read_en_i,
	input  logic [1:0]               reg_adr_i,
	input  sd_host_pkg::bus_word_t   reg_data_i,
	input  logic                     cmd_done_i,
	input  sd_host_pkg::sd_status_t  status_i,
	input  sd_host_pkg::bus_word_t   resp_arg_i,
	input  logic                     busy_i,
	output sd_host_pkg::bus_word_t   reg_data_o,
	output logic                     new_cmd_o,
	output sd_host_pkg::cmd_req_t    cmd_req_o
);
	import sd_host_pkg::*;

	bus_word_t  argument_q, command_q, response_q;
	sd_status_t status_q;
	sd_status_t status_rd; // Stored status with live busy
	logic       cmd_write;

	assign cmd_write = reg_write_en_i && (reg_adr_i == `SD_ADR_COMMAND);

	always_ff @(posedge clock) begin
		if (reset_i) begin
			new_cmd_o <= 1'b0;
			status_q  <= '0;
		end else begin
			new_cmd_o <= cmd_write; // One-cycle launch strobe
			if (cmd_write) begin
				status_q            <= '0; // Fresh command, flags cleared
				status_q.resp_index <= status_q.resp_index;
			end else if (cmd_done_i) begin
				status_q <= status_i;
			end
		end
	end

	// Payload registers
	always_ff @(posedge clock) begin
		if (reg_write_en_i && (reg_adr_i == `SD_ADR_ARGUMENT)) argument_q <= reg_data_i;
		if (cmd_write) begin
			command_q         <= reg_data_i;
			cmd_req_o.index    <= reg_data_i[5:0];   // Index field
			cmd_req_o.resp_en  <= reg_data_i[6];     // Response expected
			cmd_req_o.argument <= argument_q;
		end
		if (cmd_done_i) response_q <= resp_arg_i;
	end

	always_comb begin
		status_rd      = status_q;
		status_rd.busy = busy_i;
		reg_data_o     = '0;
		if (reg_read_en_i) begin
			case (reg_adr_i)
				`SD_ADR_ARGUMENT: reg_data_o = argument_q;
				`SD_ADR_COMMAND:  reg_data_o = command_q;
				`SD_ADR_RESPONSE: reg_data_o = response_q;
				default:          reg_data_o = {21'd0, status_rd};
			endcase
		end
	end

endmodule

/* logic/cmd_controller.sv */
// Command sequencer between the register bank and the physical layer.
// Completion status is formed in the cycle of phys_done_i, so done and
// the flags land in STATUS on the same edge that busy falls.
`timescale 1ns/1ns

module cmd_controller (
	input  logic                     clock,
	input  logic                     reset_i,
	input  logic                     new_cmd_i,
	input  sd_host_pkg::cmd_req_t    cmd_req_i,
	input  logic                     phys_done_i,
	input  sd_host_pkg::cmd_result_t phys_result_i,
	output logic                     phys_start_o,
	output sd_host_pkg::cmd_req_t    phys_req_o,
	output logic                     cmd_done_o,
	output sd_host_pkg::sd_status_t  status_o,
	output sd_host_pkg::bus_word_t   resp_arg_o,
	output logic                     busy_o
);
	import sd_host_pkg::*;

	typedef enum logic [1:0] {IDLE, ISSUE, WAIT} state_t;
	state_t   state_q;
	cmd_req_t req_q; // Request in flight

	always_ff @(posedge clock) begin
		if (reset_i) begin
			state_q <= IDLE;
		end else begin
			case (state_q)
				IDLE:    if (new_cmd_i) state_q <= ISSUE;
				ISSUE:   state_q <= WAIT; // Start pulse lasts one cycle
				WAIT:    if (phys_done_i) state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state_q == IDLE && new_cmd_i) req_q <= cmd_req_i;
	end

	assign busy_o       = (state_q != IDLE);
	assign phys_start_o = (state_q == ISSUE);
	assign phys_req_o   = req_q;
	assign cmd_done_o   = (state_q == WAIT) && phys_done_i;
	assign resp_arg_o   = phys_result_i.resp_arg;

	always_comb begin
		status_o            = '0; // Not busy once complete
		status_o.done       = 1'b1;
		status_o.timeout    = phys_result_i.timeout;
		status_o.crc_err    = phys_result_i.crc_err;
		status_o.resp_index = phys_result_i.resp_index;
		// Index only checked when a response actually came back
		status_o.index_err  = req_q.resp_en && !phys_result_i.timeout &&
			(phys_result_i.resp_index != req_q.index);
	end

	ap_no_cmd_busy: assert property (@(posedge clock) disable iff (reset_i)
		new_cmd_i |-> !busy_o);

endmodule

/* logic/cmd_phys.sv */
// CMD line physical layer: SD clock divider, 48-bit transmitter and
// short response receiver. cmd_o changes and cmd_i is sampled on the
// system edge where sd_clk_o rises. The card must leave at least one
// idle SD period after the end bit before its start bit.
// Commands without a response finish 8 SD periods after the end bit.
`timescale 1ns/1ns
`include "sd_host_macros.svh"

module cmd_phys (
	input  logic                     clock,
	input  logic                     reset_i,
	input  logic                     start_i,
	input  sd_host_pkg::cmd_req_t    req_i,
	input  logic                     cmd_i,
	output logic                     sd_clk_o,
	output logic                     cmd_o,
	output logic                     cmd_oe_o,
	output logic                     done_o,
	output sd_host_pkg::cmd_result_t result_o
);
	import sd_host_pkg::*;

	localparam int unsigned DIV_W = $clog2(`SD_CLK_DIV);
	localparam int unsigned HALF  = `SD_CLK_DIV / 2;

	typedef enum logic [2:0] {IDLE, TX, GAP, HUNT, RX, FINISH} state_t;
	state_t      state_q;
	logic [DIV_W-1:0] div_q;
	logic        tick; // sd_clk_o rises on this edge
	logic [7:0]  cnt_q; // Bit, gap and timeout counter
	logic [39:0] shift_q; // TX shifter, MSB first
	logic [46:0] rx_q; // Response bits after the start bit
	logic        resp_en_q, timeout_q, got_resp_q;
	logic        crc_clear, crc_shift, crc_bit;
	logic [6:0]  crc;

	assign tick = (div_q == DIV_W'(HALF - 1));

	assign crc_clear = (state_q == IDLE && start_i) || (state_q == TX && tick && cnt_q == 8'd48);
	assign crc_shift = tick && ((state_q == TX && cnt_q < 8'd40) ||
		(state_q == HUNT && !cmd_i) || (state_q == RX && cnt_q < 8'd39));
	assign crc_bit   = (state_q == TX) ? shift_q[39] : cmd_i;

	crc7_serial crc0 (
		.clock(clock), .reset_i(reset_i),
		.clear_i(crc_clear), .shift_i(crc_shift), .bit_i(crc_bit),
		.crc_o(crc)
	);

	always_ff @(posedge clock) begin
		if (reset_i) begin
			div_q    <= '0;
			sd_clk_o <= 1'b0;
			state_q  <= IDLE;
			cmd_o    <= 1'b1;
			cmd_oe_o <= 1'b0;
		end else begin
			div_q <= (div_q == DIV_W'(`SD_CLK_DIV - 1)) ? '0 : div_q + 1'b1;
			if (tick) sd_clk_o <= 1'b1;
			else if (div_q == DIV_W'(`SD_CLK_DIV - 1)) sd_clk_o <= 1'b0;
			case (state_q)
				IDLE: if (start_i) begin
					state_q    <= TX;
					cnt_q      <= '0;
					shift_q    <= {2'b01, req_i.index, req_i.argument}; // Start, host bit
					resp_en_q  <= req_i.resp_en;
					timeout_q  <= 1'b0;
					got_resp_q <= 1'b0;
					rx_q       <= '0;
				end
				TX: if (tick) begin
					if (cnt_q == 8'd48) begin // End bit sent, release line
						cmd_oe_o <= 1'b0;
						cmd_o    <= 1'b1;
						cnt_q    <= '0;
						state_q  <= resp_en_q ? HUNT : GAP;
					end else begin
						cmd_oe_o <= 1'b1;
						cnt_q    <= cnt_q + 1'b1;
						if (cnt_q == 8'd40) begin
							cmd_o   <= crc[6]; // CRC MSB, then rest and end bit
							shift_q <= {crc[5:0], 1'b1, 33'd0};
						end else begin
							cmd_o   <= shift_q[39];
							shift_q <= {shift_q[38:0], 1'b0};
						end
					end
				end
				GAP: if (tick) begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == 8'd7) state_q <= FINISH;
				end
				HUNT: if (tick) begin
					if (!cmd_i) begin // Start bit
						got_resp_q <= 1'b1;
						cnt_q      <= '0;
						state_q    <= RX;
					end else if (cnt_q == 8'(`SD_RESP_TIMEOUT - 1)) begin
						timeout_q <= 1'b1;
						state_q   <= FINISH;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				RX: if (tick) begin
					rx_q  <= {rx_q[45:0], cmd_i};
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == 8'd46) state_q <= FINISH; // End bit in
				end
				default: state_q <= IDLE; // FINISH lasts one cycle
			endcase
		end
	end

	assign done_o              = (state_q == FINISH);
	assign result_o.resp_index = rx_q[45:40];
	assign result_o.resp_arg   = rx_q[39:8];
	assign result_o.timeout    = timeout_q;
	assign result_o.crc_err    = got_resp_q && ((crc != rx_q[7:1]) || !rx_q[0]);

endmodule

/* logic/crc7_serial.sv */
// Bit-serial CRC7, polynomial x^7 + x^3 + 1, MSB first.
// clear_i wins over shift_i.
`timescale 1ns/1ns

module crc7_serial (
	input  logic       clock,
	input  logic       reset_i,
	input  logic       clear_i,
	input  logic       shift_i,
	input  logic       bit_i,
	output logic [6:0] crc_o
);
	logic fb;

	assign fb = bit_i ^ crc_o[6]; // Feedback into taps 3 and 0

	always_ff @(posedge clock) begin
		if (reset_i || clear_i) begin
			crc_o <= '0;
		end else if (shift_i) begin
			crc_o <= {crc_o[5:3], crc_o[2] ^ fb, crc_o[1:0], fb};
		end
	end

endmodule

/* logic/sd_host_pkg.sv */
// Shared types of the SD host command path.
// COMMAND word: bits 5:0 index, bit 6 response expected.
// STATUS word: bits 10:0 hold sd_status_t, the upper bits read as zero.
package sd_host_pkg;

	typedef logic [31:0] bus_word_t; // Bus data word

	// One command request
	typedef struct packed {
		logic [5:0]  index;    // CMD index
		logic [31:0] argument; // CMD argument
		logic        resp_en;  // Short response expected
	} cmd_req_t;

	// Outcome of one command on the line
	typedef struct packed {
		logic [5:0]  resp_index; // Echoed index, 0 if none
		logic [31:0] resp_arg;   // Response payload
		logic        timeout;    // No start bit seen
		logic        crc_err;    // Bad CRC7 or end bit
	} cmd_result_t;

	// STATUS register, busy in bit 10 down to resp_index in bits 5:0
	typedef struct packed {
		logic       busy;
		logic       done;
		logic       timeout;
		logic       crc_err;
		logic       index_err;
		logic [5:0] resp_index;
	} sd_status_t;

endpackage

/* logic/sd_host_macros.svh */
// Address map, SD clock divider and response timeout for the SD host.
// SD_CLK_DIV must be even and at least 2.
// SD_RESP_TIMEOUT counts SD clock periods and must stay below 256.
`ifndef SD_HOST_MACROS_SVH
`define SD_HOST_MACROS_SVH

// Word addresses, low two bits of the 5-bit bus address
`define SD_ADR_ARGUMENT 2'd0
`define SD_ADR_COMMAND  2'd1
`define SD_ADR_RESPONSE 2'd2
`define SD_ADR_STATUS   2'd3

// System clocks per SD clock period
`define SD_CLK_DIV 4

// SD periods to wait for a response start bit
`define SD_RESP_TIMEOUT 64

`endif
